/* tb.f */
logic/mul_pkg.sv
logic/booth_pp_gen.sv
logic/csa_reduce.sv
logic/wallace_pipe.sv
logic/mul_ctrl.sv
logic/mul_unit.sv
bench/mul_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mul_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/mul_tb.sv */
`timescale 1ns/1ns

module mul_tb import mul_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int IDLE_START = 3;
    localparam int N_RAND = 240;
    localparam int N_CORNER = 100;
    localparam int N_FLUSH = 24;
    localparam int FLUSH_SLOTS = 8;
    localparam int STIM_CYCLES = RESET_CYCLES + IDLE_START + N_RAND + N_CORNER
                                 + N_FLUSH * FLUSH_SLOTS;
    localparam int TIMEOUT = 2 * STIM_CYCLES + 100;

    // expected response plus the cycle its request was sampled
    typedef struct packed {
        logic [31:0] cyc;
        mul_rsp_t    rsp;
    } pending_t;

    logic     clock;
    logic     rst;
    logic     in_valid;
    mul_req_t req;
    logic     flush;
    logic     out_valid;
    mul_rsp_t rsp;

    pending_t         exp_q[$];
    pending_t         head;
    int unsigned      cycle;
    int unsigned      errors;
    int unsigned      final_errors;
    int unsigned      checked;
    logic [31:0]      rng;
    logic [TAG_W-1:0] tag_ctr;

    mul_unit dut (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .flush     (flush),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] corner(input int idx);
        case (idx)
            0: return 32'h0000_0000;
            1: return 32'h0000_0001;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    // 64-bit product of the extended operands with the half chosen by op
    function automatic mul_rsp_t reference(input mul_req_t r);
        logic [63:0] ax;
        logic [63:0] ay;
        logic [63:0] p;
        logic        sx;
        logic        sy;
        mul_rsp_t    o;
        sx = (r.op == OP_MULH) || (r.op == OP_MULHSU);
        sy = (r.op == OP_MULH);
        ax = sx ? {{32{r.x[31]}}, r.x} : {32'h0, r.x};
        ay = sy ? {{32{r.y[31]}}, r.y} : {32'h0, r.y};
        p = ax * ay;
        o.result = (r.op == OP_MUL) ? p[31:0] : p[63:32];
        o.tag = r.tag;
        return o;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng = xorshift32(rng);
        v = rng;
    endtask

    // about one operand in eight is a corner value
    task automatic pick_operand(output logic [31:0] v);
        logic [31:0] r;
        draw(r);
        if (r[2:0] == 3'd0) begin
            v = corner(int'(r[5:3]) % 5);
        end else begin
            draw(v);
        end
    endtask

    task automatic drive(input logic valid, input logic kill, input mul_op_e op,
                         input logic [31:0] a, input logic [31:0] b);
        @(negedge clock);
        in_valid = valid;
        flush = kill;
        req.op = op;
        req.x = a;
        req.y = b;
        req.tag = tag_ctr;
        if (valid) begin
            tag_ctr = tag_ctr + 8'd1;
        end
    endtask

    task automatic send_random(input logic valid, input logic kill);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        draw(r);
        pick_operand(a);
        pick_operand(b);
        drive(valid, kill, mul_op_e'(r[1:0]), a, b);
    endtask

    // a few requests, a one or two cycle flush and fresh requests after it
    task automatic flush_round(input int n);
        logic [31:0] r;
        int          k;
        draw(r);
        for (k = 0; k < n % 3 + 1; k++) begin
            send_random(1'b1, 1'b0);
        end
        send_random(r[0], 1'b1);
        if (n % 2 == 1) begin
            send_random(r[1], 1'b1);
        end else begin
            send_random(1'b0, 1'b0);
        end
        send_random(1'b1, 1'b0);
        send_random(1'b1, 1'b0);
        send_random(1'b0, 1'b0);
    endtask

    // scoreboard and timeout sample at the rising edge
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Done: errors found");
            $finish;
        end else if (rst) begin
            // the first reset edge has not cleared out_valid yet
            if (cycle != 0) begin
                assert (out_valid == 1'b0) else begin
                    $display("Mismatch out_valid in reset: got %h expected %h",
                             out_valid, 1'b0);
                    errors++;
                end
            end
        end else begin
            if (exp_q.size() != 0 && exp_q[0].cyc + 2 == cycle) begin
                head = exp_q.pop_front();
                assert (out_valid == 1'b1) else begin
                    $display("Mismatch out_valid: got %h expected %h (tag %h)",
                             out_valid, 1'b1, head.rsp.tag);
                    errors++;
                end
                if (out_valid) begin
                    checked++;
                    assert (rsp.result == head.rsp.result) else begin
                        $display("Mismatch rsp.result: got %h expected %h (tag %h)",
                                 rsp.result, head.rsp.result, head.rsp.tag);
                        errors++;
                    end
                    assert (rsp.tag == head.rsp.tag) else begin
                        $display("Mismatch rsp.tag: got %h expected %h",
                                 rsp.tag, head.rsp.tag);
                        errors++;
                    end
                end
            end else begin
                assert (out_valid == 1'b0) else begin
                    $display("Mismatch out_valid: got %h expected %h", out_valid, 1'b0);
                    errors++;
                end
            end
            // flush drops whatever is still in flight
            if (flush) begin
                exp_q.delete();
            end
            if (in_valid && !flush) begin
                exp_q.push_back({cycle, reference(req)});
            end
        end
    end

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        flush = 1'b0;
        req = '0;
        cycle = 0;
        errors = 0;
        final_errors = 0;
        checked = 0;
        rng = 32'hce33108e;
        tag_ctr = 8'h00;

        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        repeat (IDLE_START) send_random(1'b0, 1'b0);

        for (int i = 0; i < N_RAND; i++) begin
            logic [31:0] r;
            draw(r);
            send_random(r[1:0] != 2'b00, 1'b0);
        end

        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    drive(1'b1, 1'b0, mul_op_e'(op[1:0]), corner(i), corner(j));
                end
            end
        end

        for (int n = 0; n < N_FLUSH; n++) begin
            flush_round(n);
        end

        // two cycle latency plus margin drains the pipeline
        repeat (4) send_random(1'b0, 1'b0);

        assert (exp_q.size() == 0) else begin
            $display("scoreboard still holds %0d results at end of run", exp_q.size());
            final_errors++;
        end
        assert (checked != 0) else begin
            $display("no results reached the scoreboard");
            final_errors++;
        end

        $display("errors: %0d during run, %0d at end, %0d results checked",
                 errors, final_errors, checked);
        if (errors == 0 && final_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* logic/mul_unit.sv */
`timescale 1ns/1ns

module mul_unit import mul_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  logic     in_valid,
    input  mul_req_t req,
    input  logic     flush,
    output logic     out_valid,
    output mul_rsp_t rsp
);

    logic               x_signed;
    logic               y_signed;
    logic               advance;
    row_t [PP_ROWS-1:0] pp_rows;
    row_t               product;

    mul_ctrl u_ctrl (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .flush     (flush),
        .product   (product),
        .x_signed  (x_signed),
        .y_signed  (y_signed),
        .advance   (advance),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    booth_pp_gen u_booth (
        .x        (req.x),
        .y        (req.y),
        .x_signed (x_signed),
        .y_signed (y_signed),
        .rows     (pp_rows)
    );

    // two-stage reduction, product valid the cycle after advance
    wallace_pipe u_tree (
        .clock   (clock),
        .advance (advance),
        .rows    (pp_rows),
        .product (product)
    );

endmodule

/* logic/mul_ctrl.sv */
`timescale 1ns/1ns

module mul_ctrl import mul_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  logic     in_valid,
    input  mul_req_t req,
    input  logic     flush,
    input  row_t     product,
    output logic     x_signed,
    output logic     y_signed,
    output logic     advance,
    output logic     out_valid,
    output mul_rsp_t rsp
);

    logic             use_high;
    logic             s1_valid;
    logic             s1_high;
    logic [TAG_W-1:0] s1_tag;

    // signedness per operand and which half goes back
    always_comb begin
        x_signed = 1'b0;
        y_signed = 1'b0;
        use_high = 1'b1;
        case (req.op)
            OP_MUL: begin
                use_high = 1'b0;
            end
            OP_MULH: begin
                x_signed = 1'b1;
                y_signed = 1'b1;
            end
            OP_MULHSU: begin
                x_signed = 1'b1;
            end
            OP_MULHU: begin
                use_high = 1'b1;
            end
        endcase
    end

    // tree stage register follows every strobe
    assign advance = in_valid;

    // valids, killed by flush at either stage
    always_ff @(posedge clock) begin
        if (rst) begin
            s1_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid & ~flush;
            out_valid <= s1_valid & ~flush;
        end
    end

    // sideband beside the tree's register
    always_ff @(posedge clock) begin
        if (advance) begin
            s1_high <= use_high;
            s1_tag <= req.tag;
        end
    end

    always_ff @(posedge clock) begin
        if (s1_valid) begin
            rsp.result <= s1_high ? product[PROD_W-1:XLEN] : product[XLEN-1:0];
            rsp.tag <= s1_tag;
        end
    end

endmodule

/* logic/wallace_pipe.sv */
`timescale 1ns/1ns

module wallace_pipe import mul_pkg::*; (
    input  logic               clock,
    input  logic               advance,
    input  row_t [PP_ROWS-1:0] rows,
    output row_t               product
);

    // stage a row counts, 17 -> 12 -> 8
    localparam int A1_ROWS = rows_after(PP_ROWS);
    localparam int A2_ROWS = rows_after(A1_ROWS);

    // stage b row counts, 8 -> 6 -> 4 -> 3 -> 2
    localparam int B1_ROWS = rows_after(A2_ROWS);
    localparam int B2_ROWS = rows_after(B1_ROWS);
    localparam int B3_ROWS = rows_after(B2_ROWS);
    localparam int B4_ROWS = rows_after(B3_ROWS);

    row_t [A1_ROWS-1:0] lvl_a1;
    row_t [A2_ROWS-1:0] lvl_a2;
    row_t [A2_ROWS-1:0] stage_q;
    row_t [B1_ROWS-1:0] lvl_b1;
    row_t [B2_ROWS-1:0] lvl_b2;
    row_t [B3_ROWS-1:0] lvl_b3;
    row_t [B4_ROWS-1:0] lvl_b4;

    csa_reduce #(.IN_ROWS(PP_ROWS)) u_a1 (
        .rows_in  (rows),
        .rows_out (lvl_a1)
    );

    csa_reduce #(.IN_ROWS(A1_ROWS)) u_a2 (
        .rows_in  (lvl_a1),
        .rows_out (lvl_a2)
    );

    // pipeline cut between the two halves of the tree
    always_ff @(posedge clock) begin
        if (advance) begin
            stage_q <= lvl_a2;
        end
    end

    csa_reduce #(.IN_ROWS(A2_ROWS)) u_b1 (
        .rows_in  (stage_q),
        .rows_out (lvl_b1)
    );

    csa_reduce #(.IN_ROWS(B1_ROWS)) u_b2 (
        .rows_in  (lvl_b1),
        .rows_out (lvl_b2)
    );

    csa_reduce #(.IN_ROWS(B2_ROWS)) u_b3 (
        .rows_in  (lvl_b2),
        .rows_out (lvl_b3)
    );

    csa_reduce #(.IN_ROWS(B3_ROWS)) u_b4 (
        .rows_in  (lvl_b3),
        .rows_out (lvl_b4)
    );

    // final carry-propagate add
    assign product = lvl_b4[0] + lvl_b4[1];

endmodule

/* logic/csa_reduce.sv */
`timescale 1ns/1ns

module csa_reduce import mul_pkg::*; #(
    parameter int IN_ROWS = 3
) (
    input  row_t [IN_ROWS-1:0]             rows_in,
    output row_t [rows_after(IN_ROWS)-1:0] rows_out
);

    localparam int GROUPS = IN_ROWS / 3;
    localparam int LEFT = IN_ROWS - 3 * GROUPS;

    genvar g;
    genvar r;
    generate
        for (g = 0; g < GROUPS; g = g + 1) begin : g_fa
            row_t a;
            row_t b;
            row_t c;
            row_t maj;

            assign a = rows_in[3*g];
            assign b = rows_in[3*g+1];
            assign c = rows_in[3*g+2];

            assign maj = (a & b) | (b & c) | (a & c);

            // sum row keeps its weight
            assign rows_out[2*g] = a ^ b ^ c;
            // carry moves up one bit, top carry falls off mod 2^64
            assign rows_out[2*g+1] = {maj[PROD_W-2:0], 1'b0};
        end

        for (r = 0; r < LEFT; r = r + 1) begin : g_pass
            assign rows_out[2*GROUPS+r] = rows_in[3*GROUPS+r];
        end
    endgenerate

endmodule

/* logic/booth_pp_gen.sv */
`timescale 1ns/1ns

module booth_pp_gen import mul_pkg::*; (
    input  logic [XLEN-1:0]    x,
    input  logic [XLEN-1:0]    y,
    input  logic               x_signed,
    input  logic               y_signed,
    output row_t [PP_ROWS-1:0] rows
);

    logic [XLEN+2:0] ex_y;
    logic            x_sign;
    row_t            ex_x;
    row_t            pp_p1;
    row_t            pp_p2;
    row_t            pp_m1;
    row_t            pp_m2;

    // two sign copies on top, implicit zero below the lsb
    assign ex_y = {y_signed & y[XLEN-1], y_signed & y[XLEN-1], y, 1'b0};

    assign x_sign = x_signed & x[XLEN-1];
    assign ex_x = {{XLEN{x_sign}}, x};

    // the four nonzero multiples of x
    assign pp_p1 = ex_x;
    assign pp_p2 = ex_x << 1;
    assign pp_m1 = -ex_x;
    assign pp_m2 = (-ex_x) << 1;

    genvar j;
    generate
        for (j = 0; j < PP_ROWS; j = j + 1) begin : g_row
            logic [2:0] grp;
            logic       neg;
            logic       two;
            logic       zero;
            row_t       sel;

            assign grp = ex_y[2*j+2:2*j];

            // booth recode of one overlapping triple
            assign neg  = grp[2];
            assign zero = (grp == 3'b000) || (grp == 3'b111);
            assign two  = (grp == 3'b100) || (grp == 3'b011);

            always_comb begin
                if (zero) begin
                    sel = '0;
                end else if (neg) begin
                    sel = two ? pp_m2 : pp_m1;
                end else begin
                    sel = two ? pp_p2 : pp_p1;
                end
            end

            // row weight is 4^j
            assign rows[j] = sel << (2 * j);
        end
    endgenerate

endmodule

/* logic/mul_pkg.sv */
package mul_pkg;

    // operand and product widths
    localparam int XLEN = 32;
    localparam int PROD_W = 2 * XLEN;

    // radix-4 booth needs one extra row for unsigned multipliers
    localparam int PP_ROWS = XLEN / 2 + 1;

    // rd number plus sequence bit
    localparam int TAG_W = 8;

    // low bits of funct3 for the multiply ops
    typedef enum logic [1:0] {
        OP_MUL    = 2'd0,
        OP_MULH   = 2'd1,
        OP_MULHSU = 2'd2,
        OP_MULHU  = 2'd3
    } mul_op_e;

    typedef logic [PROD_W-1:0] row_t;

    typedef struct packed {
        mul_op_e          op;
        logic [XLEN-1:0]  x;
        logic [XLEN-1:0]  y;
        logic [TAG_W-1:0] tag;
    } mul_req_t;

    typedef struct packed {
        logic [XLEN-1:0]  result;
        logic [TAG_W-1:0] tag;
    } mul_rsp_t;

    // rows left after one 3:2 level, leftovers pass straight through
    function automatic int rows_after(input int n);
        return (n / 3) * 2 + (n % 3);
    endfunction

endpackage
